// File: verilog/accel_types_pkg.sv
`default_nettype none

package accel_types_pkg;

  // Pixel lanes carried by every beat
  localparam int UNITS = 4;

  // Pixels, weights and output words share one width
  localparam int WORD_WIDTH = 8;

  // Wide enough for CIN_MAX products of two words
  localparam int ACC_WIDTH = 20;

  // Limits of a signed output word
  localparam int WORD_MAX = 2 ** (WORD_WIDTH - 1) - 1;
  localparam int WORD_MIN = -(2 ** (WORD_WIDTH - 1));

  typedef logic signed [WORD_WIDTH-1:0] word_t;

  typedef logic signed [ACC_WIDTH-1:0] acc_t;

  // One bit per lane, set when the lane holds a valid word
  typedef logic [UNITS-1:0] keep_t;

endpackage

`default_nettype wire

// File: verilog/accel_stream_pkg.sv
`default_nettype none

package accel_stream_pkg;

  // Bit 0 enables leaky ReLU and bit 1 enables max-pool
  typedef enum logic [1:0] {
    MODE_CONV      = 2'b00,
    MODE_LRELU     = 2'b01,
    MODE_MAX       = 2'b10,
    MODE_LRELU_MAX = 2'b11
  } mode_e;

  // Input beat, one channel of UNITS pixels with its weight
  typedef struct packed {
    accel_types_pkg::word_t [accel_types_pkg::UNITS-1:0] pixels;
    accel_types_pkg::word_t                              weight;
    mode_e                                               mode;
    logic                                                cin_last;
    logic                                                last;
  } in_beat_t;

  typedef struct packed {
    accel_types_pkg::acc_t [accel_types_pkg::UNITS-1:0] sums;
    mode_e                                              mode;
    logic                                               last;
  } acc_beat_t;

  typedef struct packed {
    accel_types_pkg::word_t [accel_types_pkg::UNITS-1:0] words;
    mode_e                                               mode;
    logic                                                last;
  } word_beat_t;

  typedef struct packed {
    accel_types_pkg::word_t [accel_types_pkg::UNITS-1:0] words;
    accel_types_pkg::keep_t                              keep;
    logic                                                last;
  } out_beat_t;

endpackage

`default_nettype wire

// File: verilog/stream_skid.sv
`timescale 1ns/1ns
`default_nettype none

module stream_skid #(
  parameter int BEAT_WIDTH = 32
) (
  input  wire                   aclk,
  input  wire                   i_rst,
  input  wire                   i_valid,
  input  wire  [BEAT_WIDTH-1:0] i_data,
  output logic                  o_ready,
  output logic                  o_valid,
  output logic [BEAT_WIDTH-1:0] o_data,
  input  wire                   i_ready
);

  logic                  main_valid;
  logic [BEAT_WIDTH-1:0] main_data;
  logic                  skid_valid;
  logic [BEAT_WIDTH-1:0] skid_data;
  logic                  in_fire;
  logic                  main_free;

  // Ready comes straight from a flop so it never depends on i_ready
  assign o_ready   = ~skid_valid;
  assign o_valid   = main_valid;
  assign o_data    = main_data;
  assign in_fire   = i_valid && o_ready;
  assign main_free = ~main_valid || i_ready;

  always_ff @(posedge aclk) begin
    if (i_rst) begin
      main_valid <= 1'b0;
      skid_valid <= 1'b0;
    end else if (main_free) begin
      // The overflow entry drains first to keep beat order
      main_valid <= skid_valid || in_fire;
      skid_valid <= 1'b0;
    end else if (in_fire) begin
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (main_free) begin
      main_data <= skid_valid ? skid_data : i_data;
    end
    if (in_fire && !main_free) begin
      skid_data <= i_data;
    end
  end

  // A stalled beat must be held until the sink takes it
  a_hold_stable : assert property (@(posedge aclk) disable iff (i_rst)
    o_valid && !i_ready |=> o_valid && $stable(o_data));

endmodule

`default_nettype wire

// File: verilog/conv_mac_array.sv
`timescale 1ns/1ns
`default_nettype none

module conv_mac_array #(
  parameter int CIN_MAX = 16
) (
  input  wire                         aclk,
  input  wire                         i_rst,
  input  wire                         i_valid,
  input  wire accel_stream_pkg::in_beat_t i_beat,
  output logic                        o_ready,
  output logic                        o_valid,
  output accel_stream_pkg::acc_beat_t o_beat,
  input  wire                         i_ready
);

  localparam int UNITS = accel_types_pkg::UNITS;
  localparam int CNT_W = $clog2(CIN_MAX + 1);

  typedef enum logic {
    ST_ACC,
    ST_EMIT
  } state_e;

  state_e                state;
  accel_types_pkg::acc_t acc      [UNITS];
  accel_types_pkg::acc_t acc_next [UNITS];
  logic [CNT_W-1:0]      cin_cnt;
  logic                  in_fire;

  assign o_ready = (state == ST_ACC);
  assign o_valid = (state == ST_EMIT);
  assign in_fire = i_valid && o_ready;

  // Each lane adds pixel times weight, both sign extended before the multiply
  always_comb begin
    for (int u = 0; u < UNITS; u++) begin
      acc_next[u] = acc[u] +
                    accel_types_pkg::acc_t'($signed(i_beat.pixels[u])) *
                    accel_types_pkg::acc_t'($signed(i_beat.weight));
    end
  end

  always_ff @(posedge aclk) begin
    if (i_rst) begin
      for (int u = 0; u < UNITS; u++) begin
        acc[u] <= '0;
      end
    end else if (in_fire) begin
      for (int u = 0; u < UNITS; u++) begin
        acc[u] <= i_beat.cin_last ? '0 : acc_next[u];
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (i_rst) begin
      state   <= ST_ACC;
      cin_cnt <= '0;
    end else begin
      case (state)
        ST_ACC: begin
          if (in_fire) begin
            if (i_beat.cin_last) begin
              state   <= ST_EMIT;
              cin_cnt <= '0;
            end else begin
              cin_cnt <= cin_cnt + 1'b1;
            end
          end
        end
        ST_EMIT: begin
          if (i_ready) begin
            state <= ST_ACC;
          end
        end
        default: state <= ST_ACC;
      endcase
    end
  end

  // The finished sums include the cin_last beat itself
  always_ff @(posedge aclk) begin
    if (in_fire && i_beat.cin_last) begin
      for (int u = 0; u < UNITS; u++) begin
        o_beat.sums[u] <= acc_next[u];
      end
      o_beat.mode <= i_beat.mode;
      o_beat.last <= i_beat.last;
    end
  end

  // The accumulator width is only sized for CIN_MAX channels
  a_cin_limit : assert property (@(posedge aclk) disable iff (i_rst)
    in_fire |-> int'(cin_cnt) < CIN_MAX);

endmodule

`default_nettype wire

// File: verilog/lrelu_unit.sv
`timescale 1ns/1ns
`default_nettype none

module lrelu_unit #(
  parameter int LRELU_SHIFT = 3
) (
  input  wire                          i_valid,
  input  wire accel_stream_pkg::acc_beat_t i_beat,
  output logic                         o_ready,
  output logic                         o_valid,
  output accel_stream_pkg::word_beat_t o_beat,
  input  wire                          i_ready
);

  localparam int UNITS = accel_types_pkg::UNITS;

  accel_types_pkg::acc_t scaled [UNITS];
  logic                  lrelu_en;

  assign o_valid  = i_valid;
  assign o_ready  = i_ready;
  assign lrelu_en = (i_beat.mode == accel_stream_pkg::MODE_LRELU) ||
                    (i_beat.mode == accel_stream_pkg::MODE_LRELU_MAX);

  always_comb begin
    for (int u = 0; u < UNITS; u++) begin
      scaled[u] = i_beat.sums[u];
      // Alpha is 2^-LRELU_SHIFT, applied to negative sums only
      if (lrelu_en && i_beat.sums[u] < 0) begin
        scaled[u] = i_beat.sums[u] >>> LRELU_SHIFT;
      end
      if (scaled[u] > accel_types_pkg::WORD_MAX) begin
        o_beat.words[u] = accel_types_pkg::word_t'(accel_types_pkg::WORD_MAX);
      end else if (scaled[u] < accel_types_pkg::WORD_MIN) begin
        o_beat.words[u] = accel_types_pkg::word_t'(accel_types_pkg::WORD_MIN);
      end else begin
        o_beat.words[u] = accel_types_pkg::word_t'(scaled[u]);
      end
    end
    o_beat.mode = i_beat.mode;
    o_beat.last = i_beat.last;
  end

endmodule

`default_nettype wire

// File: verilog/maxpool_unit.sv
`timescale 1ns/1ns
`default_nettype none

module maxpool_unit (
  input  wire                          aclk,
  input  wire                          i_rst,
  input  wire                          i_valid,
  input  wire accel_stream_pkg::word_beat_t i_beat,
  output logic                         o_ready,
  output logic                         o_valid,
  output accel_stream_pkg::out_beat_t  o_beat,
  input  wire                          i_ready
);

  localparam int UNITS = accel_types_pkg::UNITS;
  localparam int HALF  = UNITS / 2;

  typedef enum logic {
    ST_FIRST,
    ST_SECOND
  } state_e;

  state_e                                     state;
  accel_types_pkg::word_t [UNITS-1:0]         hold_q;
  logic                                       max_en;
  logic                                       in_fire;

  function automatic accel_types_pkg::word_t max2(input accel_types_pkg::word_t a,
                                                  input accel_types_pkg::word_t b);
    return (a > b) ? a : b;
  endfunction

  assign max_en  = (i_beat.mode == accel_stream_pkg::MODE_MAX) ||
                   (i_beat.mode == accel_stream_pkg::MODE_LRELU_MAX);
  assign in_fire = i_valid && o_ready;

  always_comb begin
    o_beat.words = '0;
    o_beat.keep  = '1;
    o_beat.last  = i_beat.last;
    if (!max_en) begin
      o_valid      = i_valid;
      o_ready      = i_ready;
      o_beat.words = i_beat.words;
    end else if (state == ST_FIRST) begin
      // The first beat of a pair only goes into the holding register
      o_valid = 1'b0;
      o_ready = 1'b1;
    end else begin
      o_valid     = i_valid;
      o_ready     = i_ready;
      o_beat.keep = accel_types_pkg::keep_t'((1 << HALF) - 1);
      for (int k = 0; k < HALF; k++) begin
        o_beat.words[k] = max2(max2(hold_q[2*k], hold_q[2*k+1]),
                               max2(i_beat.words[2*k], i_beat.words[2*k+1]));
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (i_rst) begin
      state <= ST_FIRST;
    end else if (in_fire && max_en) begin
      state <= (state == ST_FIRST) ? ST_SECOND : ST_FIRST;
    end
  end

  always_ff @(posedge aclk) begin
    if (in_fire && max_en && state == ST_FIRST) begin
      hold_q <= i_beat.words;
    end
  end

  // An odd result count in a max packet would split a pair across packets
  a_pair_last : assert property (@(posedge aclk) disable iff (i_rst)
    in_fire && max_en && state == ST_FIRST |-> !i_beat.last);

endmodule

`default_nettype wire

// File: verilog/accel_top.sv
`timescale 1ns/1ns
`default_nettype none

module accel_top #(
  parameter int LRELU_SHIFT = 3,
  parameter int CIN_MAX     = 16
) (
  input  wire                         aclk,
  input  wire                         i_rst,
  input  wire                         i_valid,
  input  wire accel_stream_pkg::in_beat_t i_beat,
  output logic                        o_ready,
  output logic                        o_valid,
  output accel_stream_pkg::out_beat_t o_beat,
  input  wire                         i_ready
);

  localparam int ACC_BEAT_W  = $bits(accel_stream_pkg::acc_beat_t);
  localparam int WORD_BEAT_W = $bits(accel_stream_pkg::word_beat_t);
  localparam int OUT_BEAT_W  = $bits(accel_stream_pkg::out_beat_t);

  logic                         conv_valid;
  logic                         conv_ready;
  accel_stream_pkg::acc_beat_t  conv_beat;

  logic                         lrelu_in_valid;
  logic                         lrelu_in_ready;
  accel_stream_pkg::acc_beat_t  lrelu_in_beat;
  logic                         lrelu_valid;
  logic                         lrelu_ready;
  accel_stream_pkg::word_beat_t lrelu_beat;

  logic                         pool_in_valid;
  logic                         pool_in_ready;
  accel_stream_pkg::word_beat_t pool_in_beat;
  logic                         pool_valid;
  logic                         pool_ready;
  accel_stream_pkg::out_beat_t  pool_beat;

  conv_mac_array #(
    .CIN_MAX (CIN_MAX)
  ) u_conv (
    .aclk    (aclk),
    .i_rst   (i_rst),
    .i_valid (i_valid),
    .i_beat  (i_beat),
    .o_ready (o_ready),
    .o_valid (conv_valid),
    .o_beat  (conv_beat),
    .i_ready (conv_ready)
  );

  stream_skid #(
    .BEAT_WIDTH (ACC_BEAT_W)
  ) u_skid_conv (
    .aclk    (aclk),
    .i_rst   (i_rst),
    .i_valid (conv_valid),
    .i_data  (conv_beat),
    .o_ready (conv_ready),
    .o_valid (lrelu_in_valid),
    .o_data  (lrelu_in_beat),
    .i_ready (lrelu_in_ready)
  );

  lrelu_unit #(
    .LRELU_SHIFT (LRELU_SHIFT)
  ) u_lrelu (
    .i_valid (lrelu_in_valid),
    .i_beat  (lrelu_in_beat),
    .o_ready (lrelu_in_ready),
    .o_valid (lrelu_valid),
    .o_beat  (lrelu_beat),
    .i_ready (lrelu_ready)
  );

  stream_skid #(
    .BEAT_WIDTH (WORD_BEAT_W)
  ) u_skid_lrelu (
    .aclk    (aclk),
    .i_rst   (i_rst),
    .i_valid (lrelu_valid),
    .i_data  (lrelu_beat),
    .o_ready (lrelu_ready),
    .o_valid (pool_in_valid),
    .o_data  (pool_in_beat),
    .i_ready (pool_in_ready)
  );

  maxpool_unit u_pool (
    .aclk    (aclk),
    .i_rst   (i_rst),
    .i_valid (pool_in_valid),
    .i_beat  (pool_in_beat),
    .o_ready (pool_in_ready),
    .o_valid (pool_valid),
    .o_beat  (pool_beat),
    .i_ready (pool_ready)
  );

  // Output register, so the top output never depends combinationally on i_ready
  stream_skid #(
    .BEAT_WIDTH (OUT_BEAT_W)
  ) u_skid_out (
    .aclk    (aclk),
    .i_rst   (i_rst),
    .i_valid (pool_valid),
    .i_data  (pool_beat),
    .o_ready (pool_ready),
    .o_valid (o_valid),
    .o_data  (o_beat),
    .i_ready (i_ready)
  );

endmodule

`default_nettype wire

// File: dv/tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
  parameter int PERIOD_NS = 10
) (
  output logic o_clk
);

  initial begin
    o_clk = 1'b0;
    forever begin
      #(PERIOD_NS / 2);
      o_clk = ~o_clk;
    end
  end

endmodule

`default_nettype wire

// File: dv/accel_tb.sv
`timescale 1ns/1ns
`default_nettype none

module accel_tb;

  localparam int UNITS       = accel_types_pkg::UNITS;
  localparam int LRELU_SHIFT = 3;
  localparam int MAX_BEATS   = 64;
  localparam int LINE_W      = 52;
  localparam int WMAX        = 2 ** (accel_types_pkg::WORD_WIDTH - 1) - 1;
  localparam int WMIN        = -(2 ** (accel_types_pkg::WORD_WIDTH - 1));

  logic                        aclk;
  logic                        i_rst;
  logic                        i_valid;
  logic                        i_ready;
  logic                        o_ready;
  logic                        o_valid;
  accel_stream_pkg::in_beat_t  i_beat;
  accel_stream_pkg::out_beat_t o_beat;

  logic [LINE_W-1:0]           stim [MAX_BEATS];
  accel_stream_pkg::out_beat_t exp_q [$];
  int                          pkt_q [$];
  int                          n_beats;
  int                          seed = 80569;
  int                          errors = 0;
  int                          pkt_errors = 0;
  int                          beat_in_pkt = 0;
  int                          tests_run = 0;
  int                          tests_failed = 0;
  bit                          stim_loaded = 1'b0;
  bit                          input_seen = 1'b0;

  tb_clock u_clk (
    .o_clk (aclk)
  );

  accel_top #(
    .LRELU_SHIFT (LRELU_SHIFT),
    .CIN_MAX     (16)
  ) UUT (
    .aclk    (aclk),
    .i_rst   (i_rst),
    .i_valid (i_valid),
    .i_beat  (i_beat),
    .o_ready (o_ready),
    .o_valid (o_valid),
    .o_beat  (o_beat),
    .i_ready (i_ready)
  );

  // Line layout is mode, cin_last and last as one nibble each, px0 to px3, then weight
  function automatic accel_stream_pkg::in_beat_t unpack_line(input logic [LINE_W-1:0] line);
    accel_stream_pkg::in_beat_t b;
    b.mode     = accel_stream_pkg::mode_e'(line[49:48]);
    b.cin_last = line[44];
    b.last     = line[40];
    for (int u = 0; u < UNITS; u++) begin
      b.pixels[u] = line[39-8*u -: 8];
    end
    b.weight = line[7:0];
    return b;
  endfunction

  function automatic accel_types_pkg::word_t saturate_word(input int v);
    if (v > WMAX) begin
      return accel_types_pkg::word_t'(WMAX);
    end
    if (v < WMIN) begin
      return accel_types_pkg::word_t'(WMIN);
    end
    return accel_types_pkg::word_t'(v);
  endfunction

  function automatic accel_types_pkg::word_t larger(input accel_types_pkg::word_t a,
                                                    input accel_types_pkg::word_t b);
    return (a > b) ? a : b;
  endfunction

  task automatic load_stimulus();
    for (int i = 0; i < MAX_BEATS; i++) begin
      stim[i] = {4'hf, 48'(i)};
    end
    $readmemh("dv/accel_input.txt", stim);
    n_beats = 0;
    while (n_beats < MAX_BEATS && stim[n_beats][51:48] != 4'hf) begin
      n_beats++;
    end
    if (n_beats == 0) begin
      $display("ERROR: no stimulus beats could be read from dv/accel_input.txt");
      errors++;
    end
    stim_loaded = 1'b1;
  endtask

  // Reference model of the pipeline that runs over the whole stimulus up front
  task automatic build_expected();
    int                          sums [UNITS];
    accel_types_pkg::word_t      res  [UNITS];
    accel_types_pkg::word_t      held [UNITS];
    bit                          have_held;
    bit                          lrelu;
    bit                          pool;
    int                          pkt;
    int                          v;
    accel_stream_pkg::in_beat_t  b;
    accel_stream_pkg::out_beat_t o;
    have_held = 1'b0;
    pkt       = 0;
    for (int u = 0; u < UNITS; u++) begin
      sums[u] = 0;
    end
    for (int i = 0; i < n_beats; i++) begin
      b     = unpack_line(stim[i]);
      lrelu = (b.mode == accel_stream_pkg::MODE_LRELU) ||
              (b.mode == accel_stream_pkg::MODE_LRELU_MAX);
      pool  = (b.mode == accel_stream_pkg::MODE_MAX) ||
              (b.mode == accel_stream_pkg::MODE_LRELU_MAX);
      for (int u = 0; u < UNITS; u++) begin
        sums[u] += int'(b.pixels[u]) * int'(b.weight);
      end
      if (b.cin_last) begin
        for (int u = 0; u < UNITS; u++) begin
          v = sums[u];
          if (lrelu && v < 0) begin
            v = v >>> LRELU_SHIFT;
          end
          res[u]  = saturate_word(v);
          sums[u] = 0;
        end
        o.words = '0;
        o.last  = b.last;
        if (!pool) begin
          o.keep = '1;
          for (int u = 0; u < UNITS; u++) begin
            o.words[u] = res[u];
          end
          exp_q.push_back(o);
          pkt_q.push_back(pkt);
        end else if (!have_held) begin
          held      = res;
          have_held = 1'b1;
        end else begin
          o.keep = '0;
          for (int k = 0; k < UNITS / 2; k++) begin
            o.words[k] = larger(larger(held[2*k], held[2*k+1]),
                                larger(res[2*k], res[2*k+1]));
            o.keep[k]  = 1'b1;
          end
          have_held = 1'b0;
          exp_q.push_back(o);
          pkt_q.push_back(pkt);
        end
      end
      if (b.last) begin
        pkt++;
      end
    end
  endtask

  task automatic check_words(input string name,
                             input accel_types_pkg::word_t [UNITS-1:0] exp_words,
                             input accel_types_pkg::word_t [UNITS-1:0] act_words);
    if (act_words !== exp_words) begin
      $display("CHECK FAILED %s words expected %h actual %h", name, exp_words, act_words);
      errors++;
      pkt_errors++;
    end
  endtask

  task automatic check_keep(input string name,
                            input accel_types_pkg::keep_t exp_keep,
                            input accel_types_pkg::keep_t act_keep);
    if (act_keep !== exp_keep) begin
      $display("CHECK FAILED %s keep expected %b actual %b", name, exp_keep, act_keep);
      errors++;
      pkt_errors++;
    end
  endtask

  task automatic check_last(input string name, input bit exp_last, input logic act_last);
    if (act_last !== exp_last) begin
      $display("CHECK FAILED %s last expected %b actual %b", name, exp_last, act_last);
      errors++;
      pkt_errors++;
    end
  endtask

  task automatic check_output_beat();
    accel_stream_pkg::out_beat_t exp;
    int                          pkt;
    string                       name;
    if (exp_q.size() == 0) begin
      $display("ERROR: output beat arrived when no result was expected");
      errors++;
      return;
    end
    exp  = exp_q.pop_front();
    pkt  = pkt_q.pop_front();
    name = $sformatf("packet %0d beat %0d", pkt, beat_in_pkt);
    check_words(name, exp.words, o_beat.words);
    check_keep(name, exp.keep, o_beat.keep);
    check_last(name, exp.last, o_beat.last);
    beat_in_pkt++;
    if (exp.last) begin
      tests_run++;
      if (pkt_errors != 0) begin
        tests_failed++;
      end
      $display("%s packet %0d with %0d beats and %0d mismatches",
               (pkt_errors == 0) ? "PASS" : "FAIL", pkt, beat_in_pkt, pkt_errors);
      beat_in_pkt = 0;
      pkt_errors  = 0;
    end
  endtask

  // Holds each beat until a falling edge shows that it was taken
  task automatic drive_inputs();
    logic ready_seen;
    for (int i = 0; i < n_beats; i++) begin
      i_valid = 1'b1;
      i_beat  = unpack_line(stim[i]);
      do begin
        ready_seen = o_ready;
        @(negedge aclk);
      end while (ready_seen !== 1'b1);
      input_seen = 1'b1;
    end
    i_valid = 1'b0;
  endtask

  // Drives random back-pressure and checks each output beat that will transfer
  initial begin
    forever begin
      @(negedge aclk);
      i_ready = ($random(seed) & 3) != 0;
      if (!i_rst) begin
        if (!input_seen && o_valid !== 1'b0) begin
          $display("ERROR: o_valid was not low before any input beat was accepted");
          errors++;
        end
        if (o_valid === 1'b1 && i_ready) begin
          check_output_beat();
        end
      end
    end
  end

  initial begin
    wait (stim_loaded);
    #(n_beats * 400 + 2000);
    $display("Timeout: the run did not finish, %0d expected beats never arrived",
             exp_q.size());
    $display("Test failures found");
    $finish;
  end

  initial begin
    i_rst   = 1'b1;
    i_valid = 1'b0;
    i_beat  = '0;
    i_ready = 1'b0;
    load_stimulus();
    build_expected();
    repeat (8) @(posedge aclk);
    @(negedge aclk);
    i_rst = 1'b0;
    if (o_ready !== 1'b1) begin
      $display("ERROR: o_ready was not high after reset");
      errors++;
    end
    drive_inputs();
    while (exp_q.size() != 0) begin
      @(negedge aclk);
    end
    // A few more cycles so that a duplicated beat would still be seen
    repeat (20) @(negedge aclk);
    $display("Packets run %0d, packets failed %0d, errors %0d",
             tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
verilog/accel_types_pkg.sv
verilog/accel_stream_pkg.sv
verilog/stream_skid.sv
verilog/conv_mac_array.sv
verilog/lrelu_unit.sv
verilog/maxpool_unit.sv
verilog/accel_top.sv
dv/tb_clock.sv
dv/accel_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := accel_tb
FILELIST  := compile.f
OBJ_DIR   := obj_dir
PASS_MSG  := All tests passed!

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: dv/accel_input.txt
// Each line is mode, cin_last and last as one hex digit each
// followed by pixels 0 to 3 and the weight as two hex digits each
// Packet 0 in MODE_CONV with saturation in both directions
0_0_0_10_f0_7f_80_02
0_0_0_01_02_03_04_05
0_1_0_03_fd_40_c0_04
0_1_1_05_06_fa_00_ff
// Packet 1 in MODE_LRELU with negative sums
1_0_0_80_20_f6_03_07
1_1_0_10_e0_05_fe_fd
1_0_0_7f_81_02_fb_7f
1_1_1_02_02_02_02_81
// Packet 2 in MODE_MAX with four results
2_1_0_05_fb_11_22_03
2_1_0_07_f0_10_30_02
2_0_0_81_7f_01_ff_01
2_1_0_02_03_04_05_06
2_1_1_fe_fd_fc_fb_10
// Packet 3 in MODE_LRELU_MAX with two results
3_0_0_90_a0_10_20_05
3_1_0_01_02_03_04_fb
3_1_1_c0_40_e0_08_03
